//--- Makefile
# Verilator build and run for the SD init testbench

VERILATOR ?= verilator
TOP       ?= tb_sd_init
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# pass or fail comes from the log, not the exit code
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
hdl/sd_proto_pkg.sv
hdl/init_ctrl_pkg.sv
hdl/board_timebase.sv
hdl/init_sequencer.sv
hdl/cmd_shifter.sv
hdl/progress_reporter.sv
hdl/sd_init_top.sv
testbench/tb_sd_init.sv

//--- hdl/board_timebase.sv
// card clock is CLOCK_50 divided by 2*CLK_DIV and CLK_DIV must be at least 1
`timescale 1ns/1ns

module board_timebase #(
    parameter int CLK_DIV        = 250,
    parameter int HEARTBEAT_BITS = 24
) (
    input  logic CLOCK_50,
    input  logic KEY0,
    output logic sd_clk,
    output logic shift_tick,
    output logic ledr0
);

    localparam int DIV_W = $clog2(CLK_DIV + 1);

    logic [DIV_W-1:0]          div_cnt;
    logic                      div_wrap;
    logic [HEARTBEAT_BITS-1:0] beat_cnt;

    // ==================================================
    // card clock divider
    // ==================================================

    // last cycle of the current sd_clk level
    assign div_wrap = (div_cnt == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            div_cnt <= '0;
            sd_clk  <= 1'b0;
        end else if (div_wrap) begin
            div_cnt <= '0;
            sd_clk  <= ~sd_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // high level about to end, so sd_clk falls at this edge
    assign shift_tick = div_wrap && sd_clk;

    // ==================================================
    // heartbeat
    // ==================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign ledr0 = beat_cnt[HEARTBEAT_BITS-1];

    // every falling card clock edge and no other edge was flagged one cycle ahead
    a_tick_on_fall: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(sd_clk) == $past(shift_tick));

endmodule

//--- hdl/cmd_shifter.sv
// one request at a time and the CMD line is released between requests
`timescale 1ns/1ns

module cmd_shifter
    import sd_proto_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       shift_tick,
    input  logic       tx_start,
    input  sd_tx_req_t tx_req,
    output logic       cmd_out,
    output logic       cmd_oe,
    output logic       tx_done
);

    localparam int    CNT_W     = $clog2(IDLE_TICKS + 1);
    // crc covers everything before the checksum field
    localparam int    CRC_FIRST = FRAME_BITS - 8;
    // x^7 + x^3 + 1
    localparam crc7_t CRC_POLY  = 7'h09;

    logic [FRAME_BITS-1:0] shift_reg;
    logic [CNT_W-1:0]      bit_cnt;
    logic [CNT_W-1:0]      bit_total;
    crc7_t                 crc;
    tx_kind_e              kind;
    logic                  armed;
    logic                  shift_en;
    logic                  finish;
    logic                  crc_phase;
    logic                  data_bit;
    logic                  fb;

    assign bit_total = (kind == TX_FRAME) ? CNT_W'(FRAME_BITS) : CNT_W'(IDLE_TICKS);
    assign shift_en  = armed && shift_tick && (bit_cnt != bit_total);
    assign finish    = armed && shift_tick && (bit_cnt == bit_total);

    // bits 40..46 come from the crc register
    assign crc_phase = (kind == TX_FRAME) && (bit_cnt >= CNT_W'(CRC_FIRST))
                       && (bit_cnt < CNT_W'(FRAME_BITS - 1));
    assign data_bit  = crc_phase ? crc[6] : shift_reg[FRAME_BITS-1];
    assign fb        = shift_reg[FRAME_BITS-1] ^ crc[6];

    // ==================================================
    // bit counter and line enable
    // ==================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            armed   <= 1'b0;
            bit_cnt <= '0;
            cmd_oe  <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (tx_start) begin
                armed   <= 1'b1;
                bit_cnt <= '0;
            end else if (finish) begin
                // tick after the last bit, let go of CMD
                armed   <= 1'b0;
                cmd_oe  <= 1'b0;
                tx_done <= 1'b1;
            end else if (shift_en) begin
                cmd_oe  <= 1'b1;
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // frame shift register and serial crc7
    // ==================================================
    always_ff @(posedge CLOCK_50) begin
        if (tx_start) begin
            kind <= tx_req.kind;
            crc  <= '0;
            if (tx_req.kind == TX_FRAME) begin
                // start, transmission, index, arg, crc slot, end
                shift_reg <= {1'b0, 1'b1, tx_req.index, tx_req.arg, crc7_t'(0), 1'b1};
            end else begin
                shift_reg <= '1;
            end
        end else if (shift_en) begin
            cmd_out   <= data_bit;
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b1};
            if (bit_cnt < CNT_W'(CRC_FIRST)) begin
                crc <= {crc[5:0], 1'b0} ^ (fb ? CRC_POLY : crc7_t'(0));
            end else begin
                crc <= {crc[5:0], 1'b0};
            end
        end
    end

    // sequencer must wait for tx_done
    a_no_overlap: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        tx_start |-> !cmd_oe && !armed);

endmodule

//--- hdl/init_ctrl_pkg.sv
// sequencer step encoding and report byte types shared by the init controller blocks
package init_ctrl_pkg;

    // ==================================================
    // sequencer steps
    // ==================================================
    typedef enum logic [2:0] {
        ST_PREAMBLE,
        ST_CMD0,
        ST_GAP,
        ST_CMD55,
        ST_ACMD41,
        ST_DONE
    } init_step_e;

    // one ascii byte per report strobe
    typedef logic [7:0] report_char_t;

    // finished step, valid for one cycle
    typedef struct packed {
        logic       valid;
        init_step_e step;
    } step_done_t;

    // card clocks of idle after CMD0
    localparam int GAP_TICKS = 16;

endpackage

//--- hdl/init_sequencer.sv
// no card responses are sampled so the sequence runs open loop and halts after ACMD41
`timescale 1ns/1ns

module init_sequencer
    import sd_proto_pkg::*;
    import init_ctrl_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       shift_tick,
    input  logic       tx_done,
    output sd_tx_req_t tx_req,
    output logic       tx_start,
    output step_done_t step_done
);

    localparam int GAP_W = $clog2(GAP_TICKS);

    init_step_e       state;
    logic             req_issued;
    logic [GAP_W-1:0] gap_cnt;

    // step that follows a finished transfer
    function automatic init_step_e step_after(input init_step_e s);
        case (s)
            ST_PREAMBLE: return ST_CMD0;
            ST_CMD0:     return ST_GAP;
            ST_CMD55:    return ST_ACMD41;
            default:     return ST_DONE;
        endcase
    endfunction

    // ==================================================
    // request contents per step
    // ==================================================
    always_comb begin
        tx_req = '{kind: TX_IDLE_CLOCKS, index: CMD_GO_IDLE, arg: '0};
        case (state)
            ST_CMD0:   tx_req = '{kind: TX_FRAME, index: CMD_GO_IDLE, arg: '0};
            ST_CMD55:  tx_req = '{kind: TX_FRAME, index: CMD_APP, arg: '0};
            ST_ACMD41: tx_req = '{kind: TX_FRAME, index: ACMD_OP_COND, arg: ARG_HCS};
            default:   tx_req = '{kind: TX_IDLE_CLOCKS, index: CMD_GO_IDLE, arg: '0};
        endcase
    end

    // ==================================================
    // step FSM
    // ==================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ST_PREAMBLE;
            req_issued <= 1'b0;
            tx_start   <= 1'b0;
            gap_cnt    <= '0;
            step_done  <= '0;
        end else begin
            tx_start        <= 1'b0;
            step_done.valid <= 1'b0;
            case (state)
                ST_PREAMBLE, ST_CMD0, ST_CMD55, ST_ACMD41: begin
                    // one start per step, then wait for the shifter
                    if (!req_issued) begin
                        tx_start   <= 1'b1;
                        req_issued <= 1'b1;
                    end else if (tx_done) begin
                        req_issued <= 1'b0;
                        state      <= step_after(state);
                        if (state == ST_CMD55 || state == ST_ACMD41) begin
                            step_done <= '{valid: 1'b1, step: state};
                        end
                    end
                end
                ST_GAP: begin
                    // CMD0 only counts as done after the idle gap
                    if (shift_tick) begin
                        if (gap_cnt == GAP_W'(GAP_TICKS - 1)) begin
                            gap_cnt   <= '0;
                            state     <= ST_CMD55;
                            step_done <= '{valid: 1'b1, step: ST_CMD0};
                        end else begin
                            gap_cnt <= gap_cnt + 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    // halted until the next reset
                end
                default: state <= ST_DONE;
            endcase
        end
    end

    // once halted nothing is started and the shifter finishes nothing more
    a_no_start_done: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (tx_start || tx_done) |-> state != ST_DONE);

endmodule

//--- hdl/progress_reporter.sv
// report strobes have no back-pressure and are lost if nothing listens
`timescale 1ns/1ns

module progress_reporter
    import init_ctrl_pkg::*;
(
    input  logic         CLOCK_50,
    input  logic         KEY0,
    input  step_done_t   step_done,
    output report_char_t report_char,
    output logic         report_valid
);

    logic d_pending;

    // character per finished step
    function automatic report_char_t char_for(input init_step_e s);
        case (s)
            ST_CMD0:   return "0";
            ST_CMD55:  return "5";
            ST_ACMD41: return "A";
            default:   return "?";
        endcase
    endfunction

    // ==================================================
    // strobe and trailing 'D'
    // ==================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            report_valid <= 1'b0;
            d_pending    <= 1'b0;
        end else begin
            report_valid <= step_done.valid || d_pending;
            d_pending    <= step_done.valid && (step_done.step == ST_ACMD41);
        end
    end

    // byte only matters while report_valid is high
    always_ff @(posedge CLOCK_50) begin
        if (step_done.valid) begin
            report_char <= char_for(step_done.step);
        end else if (d_pending) begin
            report_char <= "D";
        end
    end

endmodule

//--- hdl/sd_init_top.sv
// SD_DAT0 is not used and DAT3 is held high so the card stays in native SD mode
`timescale 1ns/1ns

module sd_init_top
    import sd_proto_pkg::*;
    import init_ctrl_pkg::*;
#(
    parameter int CLK_DIV        = 250,
    parameter int HEARTBEAT_BITS = 24
) (
    input  logic         CLOCK_50,
    input  logic         KEY0,
    output logic         ledr0,
    output logic         sd_clk,
    output logic         sd_dat3,
    output report_char_t report_char,
    output logic         report_valid,
    inout  wire          sd_cmd
);

    logic       shift_tick;
    logic       tx_start;
    logic       tx_done;
    logic       cmd_out;
    logic       cmd_oe;
    sd_tx_req_t tx_req;
    step_done_t step_done;

    // ==================================================
    // pins
    // ==================================================
    assign sd_cmd  = cmd_oe ? cmd_out : 1'bz;
    assign sd_dat3 = 1'b1;

    // ==================================================
    // blocks
    // ==================================================
    board_timebase #(
        .CLK_DIV        (CLK_DIV),
        .HEARTBEAT_BITS (HEARTBEAT_BITS)
    ) i_timebase (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .sd_clk     (sd_clk),
        .shift_tick (shift_tick),
        .ledr0      (ledr0)
    );

    // decode, picks the next request
    init_sequencer i_sequencer (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .shift_tick (shift_tick),
        .tx_done    (tx_done),
        .tx_req     (tx_req),
        .tx_start   (tx_start),
        .step_done  (step_done)
    );

    // execute, puts bits on CMD
    cmd_shifter i_shifter (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .shift_tick (shift_tick),
        .tx_start   (tx_start),
        .tx_req     (tx_req),
        .cmd_out    (cmd_out),
        .cmd_oe     (cmd_oe),
        .tx_done    (tx_done)
    );

    // result, ascii progress bytes
    progress_reporter i_reporter (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .step_done    (step_done),
        .report_char  (report_char),
        .report_valid (report_valid)
    );

endmodule

//--- hdl/sd_proto_pkg.sv
// native-mode SD command frame types and constants for the power-up commands only
package sd_proto_pkg;

    // ==================================================
    // frame field types
    // ==================================================

    // command index field
    typedef logic [5:0] cmd_index_t;

    // 32-bit argument, sent msb first
    typedef logic [31:0] cmd_arg_t;

    // checksum over start, transmission, index and argument bits
    typedef logic [6:0] crc7_t;

    // what the shifter puts on CMD for one request
    typedef enum logic {
        TX_IDLE_CLOCKS = 1'b0,
        TX_FRAME       = 1'b1
    } tx_kind_e;

    // one transmit request, 39 bits
    typedef struct packed {
        tx_kind_e   kind;
        cmd_index_t index;
        cmd_arg_t   arg;
    } sd_tx_req_t;

    // ==================================================
    // protocol constants
    // ==================================================
    localparam int FRAME_BITS = 48;
    // ones on CMD before the first command
    localparam int IDLE_TICKS = 80;

    localparam cmd_index_t CMD_GO_IDLE  = 6'd0;
    localparam cmd_index_t CMD_APP      = 6'd55;
    localparam cmd_index_t ACMD_OP_COND = 6'd41;
    // host supports high capacity cards
    localparam cmd_arg_t   ARG_HCS      = 32'h4000_0000;

endpackage

//--- testbench/tb_sd_init.sv
// runs with CLK_DIV 4 and a 6-bit heartbeat, the card side only decodes CMD and never answers
`timescale 1ns/1ns

module tb_sd_init
    import sd_proto_pkg::*;
    import init_ctrl_pkg::*;
();

    localparam int CLK_DIV      = 4;
    localparam int HB_BITS      = 6;
    // card clocks per pass, preamble plus three frames, gap and slack
    localparam int CARD_CLOCKS  = 260;
    localparam int PASSES       = 2;
    // about 20 percent over the expected length of both passes
    localparam int MAX_CYCLES   = PASSES * CARD_CLOCKS * 2 * CLK_DIV * 6 / 5;
    // quiet time after 'D' to catch stray frames or strobes
    localparam int SETTLE_CYCLES = 20 * 2 * CLK_DIV;
    localparam int unsigned SEED = 32'hded0_c8ac;

    logic         CLOCK_50;
    logic         KEY0;
    wire          sd_cmd;
    logic         ledr0;
    logic         sd_clk;
    logic         sd_dat3;
    report_char_t report_char;
    logic         report_valid;

    int n_value_err = 0;
    int n_other_err = 0;
    int pass_no     = 0;
    int cyc         = 0;
    int first_ones  = 0;

    // card-side decoder and report tracking
    int                    lead_ones;
    int                    frames_done;
    int                    bit_n;
    int                    n_reports;
    int                    a_cycle;
    logic                  in_frame;
    logic [FRAME_BITS-1:0] frame;

    // level length tracking
    int   clk_run;
    int   beat_run;
    logic clk_seen;
    logic beat_seen;
    logic prev_clk;
    logic prev_beat;

    sd_init_top #(
        .CLK_DIV        (CLK_DIV),
        .HEARTBEAT_BITS (HB_BITS)
    ) i_dut (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .ledr0        (ledr0),
        .sd_clk       (sd_clk),
        .sd_dat3      (sd_dat3),
        .report_char  (report_char),
        .report_valid (report_valid),
        .sd_cmd       (sd_cmd)
    );

    // card side pull-up on CMD
    pullup (sd_cmd);

    always #10 CLOCK_50 = ~CLOCK_50;

    // ==================================================
    // reference model
    // ==================================================

    // serial crc7, x^7 + x^3 + 1, msb first
    function automatic crc7_t crc7(input logic [39:0] bits);
        crc7_t c;
        logic  fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    function automatic cmd_index_t expected_index(input int n);
        case (n)
            0:       return 6'd0;
            1:       return 6'd55;
            default: return 6'd41;
        endcase
    endfunction

    function automatic cmd_arg_t expected_arg(input int n);
        // only ACMD41 carries HCS
        return (n == 2) ? 32'h4000_0000 : 32'h0000_0000;
    endfunction

    function automatic report_char_t expected_char(input int n);
        case (n)
            0:       return "0";
            1:       return "5";
            2:       return "A";
            default: return "D";
        endcase
    endfunction

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_index(input string name, input cmd_index_t exp, input cmd_index_t act);
        if (act !== exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_arg(input string name, input cmd_arg_t exp, input cmd_arg_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_crc(input string name, input crc7_t exp, input crc7_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_char(input string name, input report_char_t exp,
                              input report_char_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_len(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            n_value_err++;
        end
    endtask

    // ==================================================
    // card side, sampled on rising sd_clk
    // ==================================================
    task automatic check_frame(input logic [FRAME_BITS-1:0] f, input int n);
        string tag;
        tag = $sformatf("pass%0d frame%0d", pass_no, n);
        if (n > 2) begin
            $display("pass %0d: unexpected frame %0d after ACMD41", pass_no, n);
            n_other_err++;
        end else begin
            check_bit({tag, " transmission bit"}, 1'b1, f[46]);
            check_index({tag, " index"}, expected_index(n), f[45:40]);
            check_arg({tag, " argument"}, expected_arg(n), f[39:8]);
            check_crc({tag, " crc7"}, crc7(f[47:8]), f[7:1]);
            check_bit({tag, " end bit"}, 1'b1, f[0]);
        end
    endtask

    always @(posedge sd_clk) begin
        if (KEY0) begin
            if (in_frame) begin
                frame = {frame[FRAME_BITS-2:0], sd_cmd};
                bit_n++;
                if (bit_n == FRAME_BITS) begin
                    check_frame(frame, frames_done);
                    frames_done++;
                    in_frame = 1'b0;
                end
            end else if (sd_cmd === 1'b0) begin
                // start bit
                if (frames_done == 0 && lead_ones < IDLE_TICKS) begin
                    $display("pass %0d: only %0d ones on CMD before the first start bit",
                             pass_no, lead_ones);
                    n_other_err++;
                end
                frame    = '0;
                bit_n    = 1;
                in_frame = 1'b1;
            end else if (sd_cmd === 1'b1) begin
                if (frames_done == 0) begin
                    lead_ones++;
                end
            end else begin
                $display("pass %0d: CMD line unknown at a rising card clock", pass_no);
                n_other_err++;
            end
        end
    end

    // ==================================================
    // reports and level lengths, sampled mid-cycle
    // ==================================================
    task automatic check_report();
        string tag;
        tag = $sformatf("pass%0d report%0d", pass_no, n_reports);
        if (n_reports > 3) begin
            $display("pass %0d: extra report strobe with byte 0x%h", pass_no, report_char);
            n_other_err++;
        end else begin
            check_char(tag, expected_char(n_reports), report_char);
            // '0', '5' and 'A' only after the end bit of their frame
            if (n_reports < 3 && frames_done <= n_reports) begin
                $display("pass %0d: report %0d came before its frame ended", pass_no, n_reports);
                n_other_err++;
            end
            if (n_reports == 3 && cyc != a_cycle + 1) begin
                $display("pass %0d: 'D' came %0d cycles after 'A' instead of 1",
                         pass_no, cyc - a_cycle);
                n_other_err++;
            end
            a_cycle = cyc;
        end
        n_reports++;
    endtask

    always @(negedge CLOCK_50) begin
        cyc++;
        if (!KEY0) begin
            clk_run   = 0;
            beat_run  = 0;
            clk_seen  = 1'b0;
            beat_seen = 1'b0;
            prev_clk  = sd_clk;
            prev_beat = ledr0;
        end else begin
            clk_run++;
            beat_run++;
            // first change after reset only starts the measurement
            if (sd_clk !== prev_clk) begin
                if (clk_seen) begin
                    check_len("sd_clk level length", CLK_DIV, clk_run);
                end
                clk_seen = 1'b1;
                clk_run  = 0;
            end
            if (ledr0 !== prev_beat) begin
                if (beat_seen) begin
                    check_len("ledr0 toggle period", 2 ** (HB_BITS - 1), beat_run);
                end
                beat_seen = 1'b1;
                beat_run  = 0;
            end
            prev_clk  = sd_clk;
            prev_beat = ledr0;
            if (report_valid) begin
                check_report();
            end
        end
    end

    // ==================================================
    // sequence control
    // ==================================================
    task automatic clear_trackers();
        lead_ones   = 0;
        frames_done = 0;
        bit_n       = 0;
        n_reports   = 0;
        a_cycle     = 0;
        in_frame    = 1'b0;
        frame       = '0;
    endtask

    // call right after a rising edge
    task automatic apply_reset(input int cycles);
        #2 KEY0 = 1'b0;
        repeat (cycles - 1) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        check_bit($sformatf("pass%0d reset report_valid", pass_no), 1'b0, report_valid);
        check_bit($sformatf("pass%0d reset sd_cmd released", pass_no), 1'b1, sd_cmd);
        check_bit($sformatf("pass%0d reset sd_dat3", pass_no), 1'b1, sd_dat3);
        check_bit($sformatf("pass%0d reset sd_clk", pass_no), 1'b0, sd_clk);
        clear_trackers();
        @(posedge CLOCK_50);
        #2 KEY0 = 1'b1;
    endtask

    task automatic run_pass();
        wait (n_reports == 4);
        repeat (SETTLE_CYCLES) @(posedge CLOCK_50);
        check_len($sformatf("pass%0d frame count", pass_no), 3, frames_done);
        check_len($sformatf("pass%0d report count", pass_no), 4, n_reports);
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        CLOCK_50 = 1'b0;
        KEY0     = 1'b0;
        clear_trackers();
        void'($urandom(SEED));
        // known CMD0 checksum keeps the reference honest
        check_crc("crc7 reference cmd0", 7'h4a, crc7(40'h40_0000_0000));
        pass_no = 1;
        @(posedge CLOCK_50);
        apply_reset(2);
        run_pass();
        first_ones = lead_ones;
        pass_no = 2;
        @(posedge CLOCK_50);
        apply_reset(2 + int'($urandom % 7));
        run_pass();
        check_len("pass2 preamble ones", first_ones, lead_ones);
        finish_run();
    end

    // watchdog
    initial begin
        wait (cyc >= MAX_CYCLES);
        $display("timeout: init sequence never finished within %0d cycles", MAX_CYCLES);
        n_other_err++;
        finish_run();
    end

endmodule
